//--- list.f
+incdir+bench
logic/soc_pkg.sv
logic/bus_decoder.sv
logic/l2_mem.sv
logic/apb_bridge.sv
logic/ctrl_regs.sv
logic/soc_fabric.sv
bench/tb_soc_fabric.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_soc_fabric
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/bench_tasks.svh
// Four-phase master access and compare tasks for the fabric testbench
// Included inside the testbench module, uses its port signals and counters

`ifndef BENCH_TASKS_SVH
`define BENCH_TASKS_SVH

task automatic check_word(input string what, input soc_pkg::word_t got,
                          input soc_pkg::word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_err(input string what, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_apb(input string what, input soc_pkg::apb_word_t got,
                         input soc_pkg::apb_word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

// One access on the master port, req_i held for hold cycles after ack_o
task automatic bus_access(
  input  logic           we,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::word_t wdata,
  input  soc_pkg::strb_t be,
  input  int             hold,
  output soc_pkg::word_t rdata,
  output logic           err
);
  int waited;
  @(posedge clk_i);
  #DRIVE_DELAY;
  req_i   = 1'b1;
  we_i    = we;
  addr_i  = addr;
  wdata_i = wdata;
  be_i    = be;
  waited  = 0;
  while (!ack_o && waited < WAIT_LIMIT) begin
    @(posedge clk_i);
    #DRIVE_DELAY;
    waited++;
  end
  if (!ack_o) begin
    errors++;
    $display("Timeout: ack_o never rose for the access to %h", addr);
  end
  rdata = rdata_o;
  err   = err_o;
  // Back-pressure, response must stay put
  repeat (hold) begin
    @(posedge clk_i);
    #DRIVE_DELAY;
    check_err("ack_o under back-pressure", ack_o, 1'b1);
    check_word("rdata_o under back-pressure", rdata_o, rdata);
  end
  req_i  = 1'b0;
  waited = 0;
  while (ack_o && waited < WAIT_LIMIT) begin
    @(posedge clk_i);
    #DRIVE_DELAY;
    waited++;
  end
  if (ack_o) begin
    errors++;
    $display("Timeout: ack_o stayed high after req_i dropped, access to %h", addr);
  end else begin
    // Edge that samples req_i low, then one more cycle
    check_err("ack_o falls one cycle after req_i sampled low", waited == 2, 1'b1);
  end
endtask

`endif

//--- bench/tb_soc_fabric.sv
// Testbench for the SoC fabric. Runs an access table through the master
// port and answers UART transfers with a small APB responder model

`timescale 1ns/1ns
`default_nettype none

module tb_soc_fabric;

  localparam int DRIVE_DELAY  = 1;
  localparam int WAIT_LIMIT   = 64;
  localparam int RUN_LIMIT_NS = 200000;

  logic               clk_i;
  logic               rst_n_i;
  logic               req_i;
  logic               we_i;
  soc_pkg::addr_t     addr_i;
  soc_pkg::word_t     wdata_i;
  soc_pkg::strb_t     be_i;
  logic               ack_o;
  soc_pkg::word_t     rdata_o;
  logic               err_o;
  soc_pkg::word_t     exit_o;
  soc_pkg::word_t     hw_cnt_en_o;
  logic               uart_penable_o;
  logic               uart_pwrite_o;
  soc_pkg::apb_word_t uart_paddr_o;
  logic               uart_psel_o;
  soc_pkg::apb_word_t uart_pwdata_o;
  soc_pkg::apb_word_t uart_prdata_i;
  logic               uart_pready_i;
  logic               uart_pslverr_i;

  int                 errors;
  int                 checks;
  int                 apb_count;
  int unsigned        stall_cycles;
  soc_pkg::apb_word_t rec_paddr;
  soc_pkg::apb_word_t rec_pwdata;
  logic               rec_pwrite;

  // Stimulus table, one column per queue
  string              t_name[$];
  logic               t_we[$];
  soc_pkg::addr_t     t_addr[$];
  soc_pkg::word_t     t_wdata[$];
  soc_pkg::strb_t     t_be[$];
  soc_pkg::word_t     t_rdata[$];
  logic               t_err[$];

  `include "bench_tasks.svh"

  soc_fabric DUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .be_i          (be_i),
    .ack_o         (ack_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .exit_o        (exit_o),
    .hw_cnt_en_o   (hw_cnt_en_o),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o),
    .uart_paddr_o  (uart_paddr_o),
    .uart_psel_o   (uart_psel_o),
    .uart_pwdata_o (uart_pwdata_o),
    .uart_prdata_i (uart_prdata_i),
    .uart_pready_i (uart_pready_i),
    .uart_pslverr_i(uart_pslverr_i)
  );

  always #4 clk_i = ~clk_i;

  // Responder read data, a fixed function of the APB address
  function automatic soc_pkg::apb_word_t uart_read_value(input soc_pkg::apb_word_t paddr);
    return {16'h5EED, paddr[15:0] ^ 16'hA5A5};
  endfunction

  function automatic logic in_uart(input soc_pkg::addr_t addr);
    return addr >= soc_pkg::UART_BASE && addr < soc_pkg::UART_BASE + soc_pkg::UART_LEN;
  endfunction

  task automatic add_entry(input string name, input logic we, input soc_pkg::addr_t addr,
                           input soc_pkg::word_t wdata, input soc_pkg::strb_t be,
                           input soc_pkg::word_t exp_rdata, input logic exp_err);
    t_name.push_back(name);
    t_we.push_back(we);
    t_addr.push_back(addr);
    t_wdata.push_back(wdata);
    t_be.push_back(be);
    t_rdata.push_back(exp_rdata);
    t_err.push_back(exp_err);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  //////////////////////
  // APB responder
  //////////////////////

  always begin
    @(posedge clk_i);
    #DRIVE_DELAY;
    if (uart_psel_o && !uart_penable_o) begin
      apb_count++;
      rec_paddr    = uart_paddr_o;
      rec_pwdata   = uart_pwdata_o;
      rec_pwrite   = uart_pwrite_o;
      stall_cycles = $urandom_range(3, 0);
      @(posedge clk_i);
      #DRIVE_DELAY;
      repeat (stall_cycles) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
      end
      uart_prdata_i  = uart_read_value(rec_paddr);
      uart_pslverr_i = (rec_paddr >= 32'h800);
      uart_pready_i  = 1'b1;
      @(posedge clk_i);
      #DRIVE_DELAY;
      uart_pready_i  = 1'b0;
      uart_pslverr_i = 1'b0;
      uart_prdata_i  = '0;
    end
  end

  initial begin : watchdog
    #(RUN_LIMIT_NS);
    $display("Run time limit reached before the tests finished");
    $display("Errors found");
    $finish;
  end

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin : main
    soc_pkg::word_t got_rdata;
    logic           got_err;
    soc_pkg::addr_t uart_off;
    int             errs_before;
    int             apb_before;
    void'($urandom(32'h714b_4d38));
    errors         = 0;
    checks         = 0;
    apb_count      = 0;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    wdata_i        = '0;
    be_i           = '0;
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;

    // L2 merges, 0x2000 is one L2_WORDS span higher
    add_entry("l2 full write", 1'b1, 64'h8000_0040, 64'h1122_3344_5566_7788, 8'hFF, '0, 1'b0);
    add_entry("l2 low half", 1'b1, 64'h8000_0040, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F, '0, 1'b0);
    add_entry("l2 byte 6", 1'b1, 64'h8000_0040, 64'h00EE_0000_0000_0000, 8'h40, '0, 1'b0);
    add_entry("l2 read", 1'b0, 64'h8000_0040, '0, 8'hFF, 64'h11EE_3344_CCCC_DDDD, 1'b0);
    add_entry("l2 alias read", 1'b0, 64'h8000_2040, '0, 8'hFF, 64'h11EE_3344_CCCC_DDDD, 1'b0);
    // Control registers
    add_entry("exit write", 1'b1, 64'hD000_0000, 64'hFFFF_FFFF_FFFF_00A5, 8'h01, '0, 1'b0);
    add_entry("cnt_en write", 1'b1, 64'hD000_0008, 64'h0000_0000_1234_5678, 8'h0C, '0, 1'b0);
    add_entry("exit read", 1'b0, 64'hD000_0000, '0, 8'hFF, 64'h0000_0000_0000_00A5, 1'b0);
    add_entry("cnt_en read", 1'b0, 64'hD000_0008, '0, 8'hFF, 64'h0000_0000_1234_0000, 1'b0);
    add_entry("dram base", 1'b0, 64'hD000_0010, '0, 8'hFF, 64'h8000_0000, 1'b0);
    add_entry("dram end", 1'b0, 64'hD000_0018, '0, 8'hFF, 64'hC000_0000, 1'b0);
    add_entry("dram base write", 1'b1, 64'hD000_0010, 64'h1234, 8'hFF, '0, 1'b1);
    add_entry("unknown offset", 1'b0, 64'hD000_0020, '0, 8'hFF, '0, 1'b1);
    add_entry("dram base again", 1'b0, 64'hD000_0010, '0, 8'hFF, 64'h8000_0000, 1'b0);
    // UART bridge, pslverr from offset 0x800 up
    add_entry("uart write", 1'b1, 64'hC000_0010, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, '0, 1'b0);
    add_entry("uart read", 1'b0, 64'hC000_0024, '0, 8'hFF,
              {32'h0, uart_read_value(32'h24)}, 1'b0);
    add_entry("uart slverr read", 1'b0, 64'hC000_0900, '0, 8'hFF,
              {32'h0, uart_read_value(32'h900)}, 1'b1);
    add_entry("uart slverr write", 1'b1, 64'hC000_0FF8, 64'h55, 8'hFF, '0, 1'b1);
    // Outside every window
    add_entry("unmapped read", 1'b0, 64'h1000_0000, '0, 8'hFF, '0, 1'b1);
    add_entry("past uart write", 1'b1, 64'hC000_1000, 64'h77, 8'hFF, '0, 1'b1);

    repeat (4) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    errs_before = errors;
    check_err("ack_o after reset", ack_o, 1'b0);
    check_err("err_o after reset", err_o, 1'b0);
    check_err("uart_psel_o after reset", uart_psel_o, 1'b0);
    check_err("uart_penable_o after reset", uart_penable_o, 1'b0);
    check_word("exit_o after reset", exit_o, '0);
    check_word("hw_cnt_en_o after reset", hw_cnt_en_o, '0);
    report_test("reset state", errs_before);

    for (int i = 0; i < t_addr.size(); i++) begin
      errs_before = errors;
      apb_before  = apb_count;
      bus_access(t_we[i], t_addr[i], t_wdata[i], t_be[i], 0, got_rdata, got_err);
      check_err({t_name[i], " err_o"}, got_err, t_err[i]);
      // Writes return no data worth checking
      if (!t_we[i]) begin
        check_word({t_name[i], " rdata_o"}, got_rdata, t_rdata[i]);
      end
      check_apb({t_name[i], " APB transfers"}, apb_count - apb_before,
                in_uart(t_addr[i]) ? 32'd1 : 32'd0);
      if (in_uart(t_addr[i])) begin
        uart_off = t_addr[i] - soc_pkg::UART_BASE;
        check_apb({t_name[i], " paddr"}, rec_paddr, uart_off[31:0]);
        check_err({t_name[i], " pwrite"}, rec_pwrite, t_we[i]);
        if (t_we[i]) begin
          check_apb({t_name[i], " pwdata"}, rec_pwdata, t_wdata[i][31:0]);
        end
      end
      report_test(t_name[i], errs_before);
    end

    errs_before = errors;
    check_word("exit_o", exit_o, 64'h0000_0000_0000_00A5);
    check_word("hw_cnt_en_o", hw_cnt_en_o, 64'h0000_0000_1234_0000);
    report_test("control outputs", errs_before);

    errs_before = errors;
    bus_access(1'b0, 64'h8000_0040, '0, 8'hFF, 6, got_rdata, got_err);
    check_word("held read rdata_o", got_rdata, 64'h11EE_3344_CCCC_DDDD);
    check_err("held read err_o", got_err, 1'b0);
    bus_access(1'b0, 64'hD000_0018, '0, 8'hFF, 0, got_rdata, got_err);
    check_word("read after hold rdata_o", got_rdata, 64'hC000_0000);
    report_test("back-pressure", errs_before);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/soc_fabric.sv
// Top of the SoC fabric: four-phase master port, address decoder and
// the L2, UART bridge and control register targets

`timescale 1ns/1ns
`default_nettype none

module soc_fabric (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Master port
  input  logic               req_i,
  input  logic               we_i,
  input  soc_pkg::addr_t     addr_i,
  input  soc_pkg::word_t     wdata_i,
  input  soc_pkg::strb_t     be_i,
  output logic               ack_o,
  output soc_pkg::word_t     rdata_o,
  output logic               err_o,
  // Control outputs
  output soc_pkg::word_t     exit_o,
  output soc_pkg::word_t     hw_cnt_en_o,
  // UART APB
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output soc_pkg::apb_word_t uart_paddr_o,
  output logic               uart_psel_o,
  output soc_pkg::apb_word_t uart_pwdata_o,
  input  soc_pkg::apb_word_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);

  soc_pkg::addr_t tgt_addr;
  logic           tgt_we;
  soc_pkg::word_t tgt_wdata;
  soc_pkg::strb_t tgt_be;

  logic           l2_start;
  logic           l2_done;
  soc_pkg::word_t l2_rdata;
  logic           uart_start;
  logic           uart_done;
  soc_pkg::word_t uart_rdata;
  logic           uart_err;
  logic           ctrl_start;
  logic           ctrl_done;
  soc_pkg::word_t ctrl_rdata;
  logic           ctrl_err;

  bus_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .tgt_addr_o  (tgt_addr),
    .tgt_we_o    (tgt_we),
    .tgt_wdata_o (tgt_wdata),
    .tgt_be_o    (tgt_be),
    .l2_start_o  (l2_start),
    .uart_start_o(uart_start),
    .ctrl_start_o(ctrl_start),
    .l2_done_i   (l2_done),
    .l2_rdata_i  (l2_rdata),
    .uart_done_i (uart_done),
    .uart_rdata_i(uart_rdata),
    .uart_err_i  (uart_err),
    .ctrl_done_i (ctrl_done),
    .ctrl_rdata_i(ctrl_rdata),
    .ctrl_err_i  (ctrl_err)
  );

  l2_mem i_l2 (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .start_i(l2_start),
    .we_i   (tgt_we),
    .addr_i (tgt_addr),
    .wdata_i(tgt_wdata),
    .be_i   (tgt_be),
    .done_o (l2_done),
    .rdata_o(l2_rdata)
  );

  apb_bridge i_uart_bridge (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (uart_start),
    .we_i          (tgt_we),
    .addr_i        (tgt_addr),
    .wdata_i       (tgt_wdata),
    .done_o        (uart_done),
    .rdata_o       (uart_rdata),
    .err_o         (uart_err),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o),
    .uart_paddr_o  (uart_paddr_o),
    .uart_psel_o   (uart_psel_o),
    .uart_pwdata_o (uart_pwdata_o),
    .uart_prdata_i (uart_prdata_i),
    .uart_pready_i (uart_pready_i),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_regs i_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (ctrl_start),
    .we_i       (tgt_we),
    .addr_i     (tgt_addr),
    .wdata_i    (tgt_wdata),
    .be_i       (tgt_be),
    .done_o     (ctrl_done),
    .rdata_o    (ctrl_rdata),
    .err_o      (ctrl_err),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

`default_nettype wire

//--- logic/ctrl_regs.sv
// Control register block: exit code, counter enable and the DRAM window
// One access per start pulse, answered with done on the next cycle

`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output logic           done_o,
  output soc_pkg::word_t rdata_o,
  output logic           err_o,
  output soc_pkg::word_t exit_o,
  output soc_pkg::word_t hw_cnt_en_o
);

  soc_pkg::ctrl_reg_e reg_sel;
  soc_pkg::word_t     exit_q;
  soc_pkg::word_t     hw_cnt_en_q;
  soc_pkg::word_t     rd_val;
  soc_pkg::word_t     rdata_q;
  logic               bad;
  logic               done_q;
  logic               err_q;

  assign reg_sel = soc_pkg::ctrl_reg_e'(addr_i[$bits(soc_pkg::ctrl_reg_e)-1:0]);

  // Read value and access error
  always_comb begin
    rd_val = '0;
    bad    = 1'b0;
    case (reg_sel)
      soc_pkg::EXIT:      rd_val = exit_q;
      soc_pkg::HW_CNT_EN: rd_val = hw_cnt_en_q;
      soc_pkg::DRAM_BASE_REG: begin
        rd_val = soc_pkg::DRAM_BASE;
        bad    = we_i;
      end
      soc_pkg::DRAM_END_REG: begin
        rd_val = soc_pkg::DRAM_BASE + soc_pkg::DRAM_LEN;
        bad    = we_i;
      end
      default: bad = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q      <= 1'b0;
      err_q       <= 1'b0;
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
    end else begin
      done_q <= start_i;
      if (start_i) begin
        err_q <= bad;
      end
      if (start_i && we_i && !bad) begin
        case (reg_sel)
          soc_pkg::EXIT:      exit_q <= soc_pkg::merge_be(exit_q, wdata_i, be_i);
          soc_pkg::HW_CNT_EN: hw_cnt_en_q <= soc_pkg::merge_be(hw_cnt_en_q, wdata_i, be_i);
          default:            exit_q <= exit_q;
        endcase
      end
    end
  end

  // Zero for writes and failed accesses
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rdata_q <= (we_i || bad) ? '0 : rd_val;
    end
  end

  assign done_o      = done_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule

`default_nettype wire

//--- logic/apb_bridge.sv
// Bridge from a fabric access to one APB transfer on the UART port
// Setup and access phases, waits on pready, returns prdata and pslverr

`timescale 1ns/1ns
`default_nettype none

module apb_bridge (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  logic               we_i,
  input  soc_pkg::addr_t     addr_i,
  input  soc_pkg::word_t     wdata_i,
  output logic               done_o,
  output soc_pkg::word_t     rdata_o,
  output logic               err_o,
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output soc_pkg::apb_word_t uart_paddr_o,
  output logic               uart_psel_o,
  output soc_pkg::apb_word_t uart_pwdata_o,
  input  soc_pkg::apb_word_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);

  soc_pkg::apb_state_e state_q;
  soc_pkg::apb_word_t  paddr_q;
  soc_pkg::apb_word_t  pwdata_q;
  logic                pwrite_q;
  soc_pkg::word_t      rdata_q;
  logic                err_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= soc_pkg::APB_IDLE;
    end else begin
      case (state_q)
        soc_pkg::APB_IDLE: begin
          if (start_i) begin
            state_q <= soc_pkg::APB_SETUP;
          end
        end
        soc_pkg::APB_SETUP:  state_q <= soc_pkg::APB_ACCESS;
        soc_pkg::APB_ACCESS: begin
          if (uart_pready_i) begin
            state_q <= soc_pkg::APB_DONE;
          end
        end
        default: state_q <= soc_pkg::APB_IDLE;
      endcase
    end
  end

  // Transfer fields and response
  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::APB_IDLE && start_i) begin
      paddr_q  <= addr_i[soc_pkg::APB_W-1:0];
      pwdata_q <= wdata_i[soc_pkg::APB_W-1:0];
      pwrite_q <= we_i;
    end
    if (state_q == soc_pkg::APB_ACCESS && uart_pready_i) begin
      // prdata zero-extended, nothing for writes
      rdata_q <= pwrite_q ? '0
                          : {{(soc_pkg::DATA_W-soc_pkg::APB_W){1'b0}}, uart_prdata_i};
      err_q   <= uart_pslverr_i;
    end
  end

  assign uart_psel_o    = (state_q == soc_pkg::APB_SETUP) ||
                          (state_q == soc_pkg::APB_ACCESS);
  assign uart_penable_o = (state_q == soc_pkg::APB_ACCESS);
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;
  assign uart_pwrite_o  = pwrite_q;

  assign done_o  = (state_q == soc_pkg::APB_DONE);
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  a_penable_in_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_penable_o |-> (uart_psel_o && !start_i));

  // Transfer fields keep matching the held access
  a_fields_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_psel_o |-> (uart_paddr_o == addr_i[soc_pkg::APB_W-1:0]) &&
                    (uart_pwdata_o == wdata_i[soc_pkg::APB_W-1:0]));

endmodule

`default_nettype wire

//--- logic/l2_mem.sv
// L2 word memory behind the DRAM window, byte-enabled writes and
// one-cycle reads. Upper offset bits alias onto the backed words

`timescale 1ns/1ns
`default_nettype none

module l2_mem (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output logic           done_o,
  output soc_pkg::word_t rdata_o
);

  soc_pkg::word_t                        mem_q [soc_pkg::L2_WORDS];
  logic [$clog2(soc_pkg::L2_WORDS)-1:0] word_idx;
  soc_pkg::word_t                        rdata_q;
  logic                                  done_q;

  // Drop the byte offset, keep the index bits
  assign word_idx = addr_i[$clog2(soc_pkg::STRB_W) +: $clog2(soc_pkg::L2_WORDS)];

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      if (we_i) begin
        mem_q[word_idx] <= soc_pkg::merge_be(mem_q[word_idx], wdata_i, be_i);
        rdata_q         <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= start_i;
    end
  end

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

  a_done_follows_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> ($past(start_i) && !start_i));

endmodule

`default_nettype wire

//--- logic/bus_decoder.sv
// Address decoder of the fabric. Takes four-phase requests, starts one
// target per access and holds the response until the handshake closes

`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::word_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output logic           ack_o,
  output soc_pkg::word_t rdata_o,
  output logic           err_o,
  output soc_pkg::addr_t tgt_addr_o,
  output logic           tgt_we_o,
  output soc_pkg::word_t tgt_wdata_o,
  output soc_pkg::strb_t tgt_be_o,
  output logic           l2_start_o,
  output logic           uart_start_o,
  output logic           ctrl_start_o,
  input  logic           l2_done_i,
  input  soc_pkg::word_t l2_rdata_i,
  input  logic           uart_done_i,
  input  soc_pkg::word_t uart_rdata_i,
  input  logic           uart_err_i,
  input  logic           ctrl_done_i,
  input  soc_pkg::word_t ctrl_rdata_i,
  input  logic           ctrl_err_i
);

  soc_pkg::dec_state_e state_q;
  soc_pkg::region_e    region;
  soc_pkg::region_e    region_q;
  soc_pkg::addr_t      offset;
  soc_pkg::addr_t      addr_q;
  logic                we_q;
  soc_pkg::word_t      wdata_q;
  soc_pkg::strb_t      be_q;
  soc_pkg::word_t      rdata_q;
  logic                err_q;
  logic                ack_q;
  logic                accept;
  logic                tgt_done;
  soc_pkg::word_t      tgt_rdata;
  logic                tgt_err;

  // Window match by base and length
  always_comb begin
    region = soc_pkg::RGN_NONE;
    offset = '0;
    if (addr_i >= soc_pkg::DRAM_BASE &&
        addr_i < soc_pkg::DRAM_BASE + soc_pkg::DRAM_LEN) begin
      region = soc_pkg::RGN_L2;
      offset = addr_i - soc_pkg::DRAM_BASE;
    end else if (addr_i >= soc_pkg::UART_BASE &&
                 addr_i < soc_pkg::UART_BASE + soc_pkg::UART_LEN) begin
      region = soc_pkg::RGN_UART;
      offset = addr_i - soc_pkg::UART_BASE;
    end else if (addr_i >= soc_pkg::CTRL_BASE &&
                 addr_i < soc_pkg::CTRL_BASE + soc_pkg::CTRL_LEN) begin
      region = soc_pkg::RGN_CTRL;
      offset = addr_i - soc_pkg::CTRL_BASE;
    end
  end

  // New access only once the previous ack has dropped
  assign accept = (state_q == soc_pkg::DEC_IDLE) && req_i && !ack_q;

  assign l2_start_o   = accept && (region == soc_pkg::RGN_L2);
  assign uart_start_o = accept && (region == soc_pkg::RGN_UART);
  assign ctrl_start_o = accept && (region == soc_pkg::RGN_CTRL);

  // Fields follow the master until captured
  assign tgt_addr_o  = (state_q == soc_pkg::DEC_IDLE) ? offset : addr_q;
  assign tgt_we_o    = (state_q == soc_pkg::DEC_IDLE) ? we_i : we_q;
  assign tgt_wdata_o = (state_q == soc_pkg::DEC_IDLE) ? wdata_i : wdata_q;
  assign tgt_be_o    = (state_q == soc_pkg::DEC_IDLE) ? be_i : be_q;

  // Listen only to the target that was started
  always_comb begin
    tgt_done  = 1'b0;
    tgt_rdata = '0;
    tgt_err   = 1'b0;
    case (region_q)
      soc_pkg::RGN_L2: begin
        tgt_done  = l2_done_i;
        tgt_rdata = l2_rdata_i;
      end
      soc_pkg::RGN_UART: begin
        tgt_done  = uart_done_i;
        tgt_rdata = uart_rdata_i;
        tgt_err   = uart_err_i;
      end
      soc_pkg::RGN_CTRL: begin
        tgt_done  = ctrl_done_i;
        tgt_rdata = ctrl_rdata_i;
        tgt_err   = ctrl_err_i;
      end
      default: begin
        tgt_done = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= soc_pkg::DEC_IDLE;
      region_q <= soc_pkg::RGN_NONE;
      err_q    <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= (state_q == soc_pkg::DEC_ACK);
      case (state_q)
        soc_pkg::DEC_IDLE: begin
          if (accept) begin
            region_q <= region;
            if (region == soc_pkg::RGN_NONE) begin
              err_q   <= 1'b1;
              state_q <= soc_pkg::DEC_ACK;
            end else begin
              state_q <= soc_pkg::DEC_BUSY;
            end
          end
        end
        soc_pkg::DEC_BUSY: begin
          if (tgt_done) begin
            err_q   <= tgt_err;
            state_q <= soc_pkg::DEC_ACK;
          end
        end
        soc_pkg::DEC_ACK: begin
          if (!req_i) begin
            state_q <= soc_pkg::DEC_IDLE;
          end
        end
        default: state_q <= soc_pkg::DEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= offset;
      we_q    <= we_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    if (accept && region == soc_pkg::RGN_NONE) begin
      rdata_q <= '0;
    end else if (state_q == soc_pkg::DEC_BUSY && tgt_done) begin
      rdata_q <= tgt_rdata;
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i));

  // Starts and target answers never share a cycle
  a_single_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({l2_start_o, uart_start_o, ctrl_start_o,
              l2_done_i, uart_done_i, ctrl_done_i}));

endmodule

`default_nettype wire

//--- logic/soc_pkg.sv
// Widths, address map and shared types of the SoC memory fabric
// Every RTL module refers to these by scoped names

`default_nettype none

package soc_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned ADDR_W = 64;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned STRB_W = DATA_W / 8;
  // UART data and APB address
  localparam int unsigned APB_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [APB_W-1:0] apb_word_t;

  ////////////////////
  // Address map
  ////////////////////

  localparam addr_t DRAM_BASE = 64'h8000_0000;
  localparam addr_t DRAM_LEN  = 64'h4000_0000;
  localparam addr_t UART_BASE = 64'hC000_0000;
  localparam addr_t UART_LEN  = 64'h1000;
  localparam addr_t CTRL_BASE = 64'hD000_0000;
  localparam addr_t CTRL_LEN  = 64'h1000;

  // Words backed in L2, the DRAM window aliases onto them
  localparam int unsigned L2_WORDS = 1024;

  ////////////////////
  // Enums
  ////////////////////

  typedef enum logic [1:0] {
    RGN_L2,
    RGN_UART,
    RGN_CTRL,
    RGN_NONE
  } region_e;

  // Offsets inside the control window
  typedef enum logic [11:0] {
    EXIT          = 12'h000,
    HW_CNT_EN     = 12'h008,
    DRAM_BASE_REG = 12'h010,
    DRAM_END_REG  = 12'h018
  } ctrl_reg_e;

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_BUSY,
    DEC_ACK
  } dec_state_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS,
    APB_DONE
  } apb_state_e;

  // Byte-enabled merge of new data into an old word
  function automatic word_t merge_be(word_t old_w, word_t new_w, strb_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire
